/* sim.f */
videoPkg.sv
cpuPkg.sv
fixLayer.sv
lineBuffer.sv
paletteMux.sv
watchdog.sv
neoPixelPath.sv
neoPixelPath_props.sv
neoPixelPath_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the pixel path testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ns \
	--top-module neoPixelPath_tb -f sim.f -o simv
./obj_dir/simv

/* neoPixelPath_tb.sv */
`timescale 1ns/1ns

module neoPixelPath_tb;

	// One table row, all DUT inputs plus the expected results
	typedef struct packed
	{
		videoPkg::xT         hcount;
		logic                lbRead;
		logic                bankSel;
		videoPkg::sprWriteT  sprWr;
		logic                sprWrEn;
		logic [7:0]          fixData;
		videoPkg::fixPalT    fixPal;
		logic                fixLoad;
		cpuPkg::cpuBusT      cpu;
		videoPkg::palAddrT   expPal;	// palAddr two cycles later
		logic                expRst;	// sysReset one cycle later
	} rowT;

	logic S1H1;
	logic nS1H1;
	videoPkg::xT hcount;
	logic lbRead;
	logic bankSel;
	videoPkg::sprWriteT sprWr;
	logic sprWrEn;
	logic [7:0] fixData;
	videoPkg::fixPalT fixPal;
	logic fixLoad;
	cpuPkg::cpuBusT cpu;
	videoPkg::palAddrT palAddr;
	logic sysReset;

	rowT tbl[$];
	rowT cur;	// Row being built
	int seed = 60374;
	int cycles = 0;
	int cycleLimit = 0;	// Set once the table is known

	// Reference model of the line buffer, fix latch and watchdog
	videoPkg::sprPixelT modelMem [2][videoPkg::lineWidth];
	bit modelValid [2][videoPkg::lineWidth];	// All slots empty after reset
	logic [7:0] modelFixData = 8'h00;
	videoPkg::fixPalT modelFixPal = 4'h0;
	int idleCnt = 0;
	int pulseLeft = 0;

	neoPixelPath dut_i
	(
		.S1H1(S1H1), .nS1H1(nS1H1), .hcount(hcount), .lbRead(lbRead), .bankSel(bankSel),
		.sprWr(sprWr), .sprWrEn(sprWrEn), .fixData(fixData), .fixPal(fixPal),
		.fixLoad(fixLoad), .cpu(cpu), .palAddr(palAddr), .sysReset(sysReset)
	);

	initial
	begin
		S1H1 = 1'b0;
		forever #4 S1H1 = ~S1H1;	// 8 ns period
	end

	always @(posedge S1H1)
	begin
		cycles = cycles + 1;
		if (cycleLimit != 0 && cycles >= cycleLimit)
			stopRun("Timeout, the table did not finish within the cycle limit");
	end

	task automatic stopRun(input string why);
		$display("=== FAIL ===");
		$fatal(1, "%s", why);
	endtask

	task automatic checkPalAddr(input videoPkg::palAddrT exp, input int row);
		if (palAddr !== exp)
		begin
			$display("ERROR %0t ns: row %0d palAddr %h, expected %h", $time, row, palAddr, exp);
			stopRun("palAddr mismatch");
		end
	endtask

	task automatic checkReset(input logic exp, input int row);
		if (sysReset !== exp)
		begin
			$display("ERROR %0t ns: row %0d sysReset %b, expected %b", $time, row, sysReset, exp);
			stopRun("sysReset mismatch");
		end
	endtask

	// Idle row, bank 0 written, bank 1 shown
	task automatic clearRow();
		cur = '0;
	endtask

	function automatic cpuPkg::cpuBusT busCycle(input logic [23:0] addr, input logic rw);
		return '{addr: addr, rw: rw, lds: 1'b0, strobe: 1'b1};
	endfunction

	task automatic driveRow(input rowT r);
		hcount = r.hcount;
		lbRead = r.lbRead;
		bankSel = r.bankSel;
		sprWr = r.sprWr;
		sprWrEn = r.sprWrEn;
		fixData = r.fixData;
		fixPal = r.fixPal;
		fixLoad = r.fixLoad;
		cpu = r.cpu;
	endtask

	// Works out the expected results of cur and appends it
	task automatic pushRow();
		videoPkg::sprPixelT spr;
		videoPkg::colorT nib;
		logic rdBank;
		logic kick;
		spr = videoPkg::sprPixelT'(videoPkg::backdropAddr);
		rdBank = ~cur.bankSel;
		if (cur.lbRead && int'(cur.hcount) < videoPkg::lineWidth)
		begin
			if (modelValid[rdBank][cur.hcount])
				spr = modelMem[rdBank][cur.hcount];
			modelValid[rdBank][cur.hcount] = 1'b0;	// Slot emptied by the read
		end
		if (cur.sprWrEn && cur.sprWr.color != 4'h0)
		begin
			modelMem[cur.bankSel][cur.sprWr.x] = '{pal: cur.sprWr.pal, color: cur.sprWr.color};
			modelValid[cur.bankSel][cur.sprWr.x] = 1'b1;
		end
		if (cur.fixLoad)
		begin
			modelFixData = cur.fixData;	// Same cycle load is seen at once
			modelFixPal = cur.fixPal;
		end
		nib = cur.hcount[0] ? modelFixData[7:4] : modelFixData[3:0];
		if (cur.cpu.strobe && cur.cpu.addr[23:22] == cpuPkg::palRegionHi)
			cur.expPal = cur.cpu.addr[12:1];
		else if (nib != 4'h0)
			cur.expPal = {4'h0, modelFixPal, nib};
		else
			cur.expPal = {spr.pal, spr.color};
		// Watchdog, one step per row
		kick = cur.cpu.strobe && !cur.cpu.rw && !cur.cpu.lds
			&& cur.cpu.addr[23:16] == cpuPkg::wdRegion;
		if (pulseLeft > 0)
			pulseLeft--;
		else if (kick)
			idleCnt = 0;
		else if (idleCnt == cpuPkg::wdTimeout - 1)
		begin
			idleCnt = 0;
			pulseLeft = cpuPkg::wdPulse;
		end
		else
			idleCnt++;
		cur.expRst = (pulseLeft > 0);
		tbl.push_back(cur);
	endtask

	task automatic buildTable();
		videoPkg::xT xs [8];
		int k;
		for (k = 0; k < 8; k++)	// Empty bank shows backdrop
		begin
			clearRow();
			cur.hcount = videoPkg::xT'(k);
			cur.lbRead = 1'b1;
			if (k == 0)
				cur.cpu = busCycle(24'h300000, 1'b0);	// Kick
			pushRow();
		end
		for (k = 0; k < 8; k++)	// Random sprite pixels into bank 0
		begin
			clearRow();
			xs[k] = videoPkg::xT'(k * 5 + ($random(seed) & 3));
			cur.sprWr = '{x: xs[k], pal: 8'h40 + 8'(k), color: videoPkg::colorT'($random(seed))};
			if (cur.sprWr.color == 4'h0)
				cur.sprWr.color = 4'hF;
			cur.sprWrEn = 1'b1;
			pushRow();
		end
		clearRow();
		cur.sprWr = '{x: xs[2], pal: 8'hEE, color: 4'h0};	// Transparent, skipped
		cur.sprWrEn = 1'b1;
		pushRow();
		for (k = 0; k <= 40; k++)	// Flip banks and read back, last read repeats
		begin
			clearRow();
			cur.bankSel = 1'b1;
			cur.hcount = (k == 40) ? xs[3] : videoPkg::xT'(k);
			cur.lbRead = 1'b1;
			pushRow();
		end
		for (k = 0; k < 16; k++)	// Bank 1 writes, then fix layer over readout
		begin
			clearRow();
			cur.bankSel = (k < 8);
			cur.sprWr = '{x: videoPkg::xT'(100 + k), pal: 8'h3C, color: videoPkg::colorT'(k + 1)};
			cur.sprWrEn = (k < 8);
			cur.hcount = videoPkg::xT'(92 + k);
			cur.lbRead = (k >= 8);
			cur.fixLoad = (k == 8 || k == 12);
			cur.fixData = (k == 8) ? 8'hA0 : 8'h05;
			cur.fixPal = (k == 8) ? 4'h7 : 4'h2;
			pushRow();
		end
		for (k = 0; k < 8; k++)	// CPU against opaque fix and sprites
		begin
			clearRow();
			cur.bankSel = (k < 4);
			cur.sprWr = '{x: videoPkg::xT'(200 + k), pal: 8'h5A, color: 4'h9};
			cur.sprWrEn = (k < 4);
			cur.hcount = videoPkg::xT'(196 + k);
			cur.lbRead = (k >= 4);
			cur.fixLoad = (k == 4);
			cur.fixData = 8'h99;
			cur.fixPal = 4'h3;
			if (k == 5)
				cur.cpu = busCycle(24'h401578, 1'b1);	// Palette word 0xABC
			if (k == 6)
				cur.cpu = busCycle(24'h802468, 1'b0);	// Outside palette region
			if (k == 7)
				cur.cpu = busCycle(24'h7F0F0E, 1'b0);
			pushRow();
		end
		for (k = 0; k < 360 + cpuPkg::wdTimeout + cpuPkg::wdPulse + 12; k++)
		begin
			clearRow();
			if (k == 0 || k == 180 || k == 360)	// Last kick, then the watchdog fires
				cur.cpu = busCycle(24'h30ABCD, 1'b0);
			pushRow();
		end
	endtask

	initial
	begin
		int n;
		int i;
		nS1H1 = 1'b1;
		clearRow();
		driveRow(cur);
		buildTable();
		n = tbl.size();
		cycleLimit = n + cpuPkg::wdTimeout + 50;
		repeat (3) @(posedge S1H1);
		#1;
		nS1H1 = 1'b0;
		for (i = 0; i < n + 2; i++)
		begin
			if (i > 0)
			begin
				@(posedge S1H1);
				#1;
			end
			if (i >= 1 && i <= n)
				checkReset(tbl[i-1].expRst, i - 1);
			if (i >= 2)
				checkPalAddr(tbl[i-2].expPal, i - 2);
			if (i < n)
				driveRow(tbl[i]);
			else
			begin
				clearRow();
				driveRow(cur);
			end
		end
		$display("=== PASS ===");
		$finish;
	end

endmodule

/* neoPixelPath_props.sv */
`timescale 1ns/1ns

module neoPixelPath_props
(
	input  logic                 S1H1,
	input  logic                 nS1H1,
	input  cpuPkg::cpuBusT       cpu,
	input  videoPkg::palAddrT    palAddr,
	input  logic                 sysReset
);

	logic cpuPal;	// Palette access on the bus

	assign cpuPal = cpu.strobe && (cpu.addr[23:22] == cpuPkg::palRegionHi);

	// Pulse is high for wdPulse cycles, low before it
	pulseLength: assert property (@(posedge S1H1) disable iff (nS1H1)
		$fell(sysReset) |-> $past(sysReset, cpuPkg::wdPulse) && !$past(sysReset, cpuPkg::wdPulse + 1))
		else $error("sysReset pulse is not %0d cycles long", cpuPkg::wdPulse);

	resetClear: assert property (@(posedge S1H1) $fell(nS1H1) |-> palAddr == '0)
		else $error("palAddr is not 0 after reset");

	// CPU wins two cycles on
	cpuWins: assert property (@(posedge S1H1) disable iff (nS1H1)
		cpuPal |-> ##2 palAddr == $past(cpu.addr[12:1], 2))
		else $error("CPU palette access did not reach palAddr");

endmodule

bind neoPixelPath neoPixelPath_props propsI
(
	.S1H1(S1H1), .nS1H1(nS1H1), .cpu(cpu), .palAddr(palAddr), .sysReset(sysReset)
);

/* neoPixelPath.sv */
`timescale 1ns/1ns

module neoPixelPath
(
	input  logic                 S1H1,
	input  logic                 nS1H1,
	input  videoPkg::xT          hcount,	// Current output x
	input  logic                 lbRead,	// Line buffer readout enable
	input  logic                 bankSel,	// Write bank select
	input  videoPkg::sprWriteT   sprWr,
	input  logic                 sprWrEn,
	input  logic [7:0]           fixData,
	input  videoPkg::fixPalT     fixPal,
	input  logic                 fixLoad,
	input  cpuPkg::cpuBusT       cpu,
	output videoPkg::palAddrT    palAddr,
	output logic                 sysReset
);

	// Stage 1 results
	videoPkg::fixPixelT fixPix;
	videoPkg::sprPixelT sprPix;

	fixLayer fixI
	(
		.S1H1(S1H1), .nS1H1(nS1H1),
		.fixData(fixData), .fixPal(fixPal), .fixLoad(fixLoad),
		.half(hcount[0]),	// Even dot low nibble
		.fixPix(fixPix)
	);

	lineBuffer lbI
	(
		.S1H1(S1H1), .nS1H1(nS1H1),
		.bankSel(bankSel), .wr(sprWr), .wrEn(sprWrEn),
		.rdX(hcount), .rdEn(lbRead),
		.rdPix(sprPix)
	);

	// Stage 2, priority choice
	paletteMux muxI
	(
		.S1H1(S1H1), .nS1H1(nS1H1),
		.cpu(cpu), .fixPix(fixPix), .sprPix(sprPix),
		.palAddr(palAddr)
	);

	watchdog wdI
	(
		.S1H1(S1H1), .nS1H1(nS1H1), .cpu(cpu), .sysReset(sysReset)
	);

endmodule

/* watchdog.sv */
`timescale 1ns/1ns

module watchdog
(
	input  logic            S1H1,
	input  logic            nS1H1,
	input  cpuPkg::cpuBusT  cpu,
	output logic            sysReset
);

	logic                          kick;
	logic [cpuPkg::wdCntW-1:0]     idleCnt;	// Cycles since last kick
	logic [cpuPkg::wdPulseW-1:0]   pulseCnt;	// Remaining reset cycles
	logic                          expired;

	// Byte write to $30xxxx
	assign kick = cpu.strobe && !cpu.rw && !cpu.lds && (cpu.addr[23:16] == cpuPkg::wdRegion);

	assign expired = (idleCnt == cpuPkg::wdCntW'(cpuPkg::wdTimeout - 1));

	always_ff @(posedge S1H1 or posedge nS1H1)
	begin
		if (nS1H1)
		begin
			idleCnt <= '0;
			pulseCnt <= '0;
			sysReset <= 1'b0;
		end
		else if (sysReset)
		begin
			// Pulse in progress, kicks ignored
			pulseCnt <= pulseCnt - 1'b1;
			if (pulseCnt == 1)
				sysReset <= 1'b0;	// Last cycle, counting resumes from 0
		end
		else if (kick)
			idleCnt <= '0;	// Software is alive
		else if (expired)
		begin
			idleCnt <= '0;
			pulseCnt <= cpuPkg::wdPulseW'(cpuPkg::wdPulse);
			sysReset <= 1'b1;	// High from the next cycle
		end
		else
			idleCnt <= idleCnt + 1'b1;
	end

endmodule

/* paletteMux.sv */
`timescale 1ns/1ns

module paletteMux
(
	input  logic                 S1H1,
	input  logic                 nS1H1,
	input  cpuPkg::cpuBusT       cpu,
	input  videoPkg::fixPixelT   fixPix,	// From stage 1
	input  videoPkg::sprPixelT   sprPix,	// From stage 1
	output videoPkg::palAddrT    palAddr
);

	logic               cpuPal;	// Palette access this cycle
	logic               cpuPalQ;	// Lined up with stage 1
	videoPkg::palAddrT  cpuAddrQ;
	videoPkg::palAddrT  fixAddr;
	videoPkg::palAddrT  sprAddr;

	// CPU decode, $400000-$7FFFFF
	assign cpuPal = cpu.strobe && (cpu.addr[23:22] == cpuPkg::palRegionHi);

	// Fix uses the first 16 palettes
	assign fixAddr = {4'h0, fixPix.pal, fixPix.color};
	assign sprAddr = {sprPix.pal, sprPix.color};

	// Word address, delayed to match stage 1
	always_ff @(posedge S1H1)
		cpuAddrQ <= cpu.addr[12:1];

	always_ff @(posedge S1H1 or posedge nS1H1)
	begin
		if (nS1H1)
		begin
			cpuPalQ <= 1'b0;
			palAddr <= '0;
		end
		else
		begin
			cpuPalQ <= cpuPal;
			// CPU first, then opaque fix, sprites last
			if (cpuPalQ)
				palAddr <= cpuAddrQ;
			else if (fixPix.opaque)
				palAddr <= fixAddr;
			else
				palAddr <= sprAddr;
		end
	end

endmodule

/* lineBuffer.sv */
`timescale 1ns/1ns

module lineBuffer
(
	input  logic                 S1H1,
	input  logic                 nS1H1,
	input  logic                 bankSel,	// Write bank, read from the other one
	input  videoPkg::sprWriteT   wr,
	input  logic                 wrEn,
	input  videoPkg::xT          rdX,
	input  logic                 rdEn,
	output videoPkg::sprPixelT   rdPix
);

	localparam videoPkg::sprPixelT clearPix = videoPkg::sprPixelT'(videoPkg::backdropAddr);

	// Pixel storage with the two banks side by side
	videoPkg::sprPixelT mem [2][videoPkg::lineWidth];

	// Slot holds a pixel written since its last readout
	logic [1:0][videoPkg::lineWidth-1:0] valid;

	logic wrBank;
	logic rdBank;
	logic wrHit;	// Write actually lands
	logic rdHit;	// Read inside the bank
	logic slotFull;

	assign wrBank = bankSel;
	assign rdBank = ~bankSel;

	// Transparent pixels are skipped so sprites behind stay
	assign wrHit = wrEn && (wr.color != '0) && (wr.x < videoPkg::lineWidth);
	assign rdHit = rdEn && (rdX < videoPkg::lineWidth);
	assign slotFull = rdHit && valid[rdBank][rdX];

	// Pixel RAM for both banks
	always_ff @(posedge S1H1)
	begin
		if (wrHit)
			mem[wrBank][wr.x] <= '{pal: wr.pal, color: wr.color};
	end

	// Valid flags and read register
	always_ff @(posedge S1H1 or posedge nS1H1)
	begin
		if (nS1H1)
		begin
			valid <= '0;	// Every slot reads as backdrop
			rdPix <= clearPix;
		end
		else
		begin
			if (wrHit)
				valid[wrBank][wr.x] <= 1'b1;
			if (rdHit)
				valid[rdBank][rdX] <= 1'b0;	// Clear on read
			// Banks differ so the two updates never collide
			if (slotFull)
				rdPix <= mem[rdBank][rdX];
			else
				rdPix <= clearPix;	// Backdrop for an empty slot, no read or x off the end
		end
	end

endmodule

/* fixLayer.sv */
`timescale 1ns/1ns

module fixLayer
(
	input  logic                 S1H1,
	input  logic                 nS1H1,
	input  logic [7:0]           fixData,	// Two pixels per byte
	input  videoPkg::fixPalT     fixPal,
	input  logic                 fixLoad,	// Comes on even x
	input  logic                 half,	// Nibble select
	output videoPkg::fixPixelT   fixPix
);

	logic [7:0]        dataQ;	// Latched tile byte
	videoPkg::fixPalT  palQ;	// Latched palette
	logic [7:0]        dataCur;
	videoPkg::fixPalT  palCur;
	videoPkg::colorT   nibble;

	// A load this cycle bypasses the latch
	assign dataCur = fixLoad ? fixData : dataQ;
	assign palCur = fixLoad ? fixPal : palQ;

	// Low nibble on even dots, high nibble on odd dots
	assign nibble = half ? dataCur[7:4] : dataCur[3:0];

	always_ff @(posedge S1H1 or posedge nS1H1)
	begin
		if (nS1H1)
		begin
			dataQ <= '0;	// Nothing shown until first load
			palQ <= '0;
			fixPix <= '0;
		end
		else
		begin
			if (fixLoad)
			begin
				dataQ <= fixData;
				palQ <= fixPal;
			end
			fixPix <= '{pal: palCur, color: nibble, opaque: |nibble};	// Stage 1
		end
	end

endmodule

/* cpuPkg.sv */
package cpuPkg;

	// 68k style bus cycle as seen by the video chip
	typedef struct packed
	{
		logic [23:0] addr;	// Byte address
		logic        rw;	// 1 read, 0 write
		logic        lds;	// Lower data strobe, active low
		logic        strobe;	// Cycle valid
	} cpuBusT;

	// Address decode
	localparam logic [1:0] palRegionHi = 2'b01;	// $400000-$7FFFFF
	localparam logic [7:0] wdRegion = 8'h30;	// $300000 kick

	// Watchdog limits
	localparam int wdTimeout = 200;	// Idle cycles before firing
	localparam int wdPulse = 8;	// Reset pulse length

	// Counter widths derived from the limits
	localparam int wdCntW = $clog2(wdTimeout);
	localparam int wdPulseW = $clog2(wdPulse + 1);

endpackage

/* videoPkg.sv */
package videoPkg;

	// Line buffer geometry
	localparam int lineWidth = 384;	// Pixel slots per bank

	// Basic pixel fields
	typedef logic [8:0]  xT;	// Pixel x position
	typedef logic [3:0]  colorT;	// Colour index, 0 is transparent
	typedef logic [7:0]  palIdxT;	// Sprite palette number
	typedef logic [3:0]  fixPalT;	// Fix palette number
	typedef logic [11:0] palAddrT;	// Palette RAM address

	// Empty slot shows the backdrop colour (last palette entry)
	localparam palAddrT backdropAddr = 12'hFFF;

	// One sprite pixel going into the line buffer
	typedef struct packed
	{
		xT      x;	// Slot in the bank
		palIdxT pal;
		colorT  color;
	} sprWriteT;

	// One sprite pixel coming out of the line buffer
	typedef struct packed
	{
		palIdxT pal;
		colorT  color;
	} sprPixelT;

	// One fix layer pixel, ready for the priority mux
	typedef struct packed
	{
		fixPalT pal;
		colorT  color;
		logic   opaque;	// Colour is nonzero
	} fixPixelT;

endpackage
